//--- tlbConfigPkg.sv
// TLB geometry, address widths and response credit sizing
`default_nettype none

package tlbConfigPkg;

	// 32-bit addresses with 4 KiB pages
	localparam int VirtAddrWidth = 32;
	localparam int PhysAddrWidth = 32;
	localparam int PageOffsetWidth = 12;
	localparam int VpnWidth = VirtAddrWidth - PageOffsetWidth;
	localparam int PpnWidth = PhysAddrWidth - PageOffsetWidth;
	localparam int AsidWidth = 8;

	// set index is taken from the low bits of the vpn
	localparam int SetCount = 16;
	localparam int SetIndexWidth = $clog2(SetCount);
	localparam int WayCount = 4;
	localparam int WayIndexWidth = $clog2(WayCount);

	// bulk invalidation stamp
	localparam int GenWidth = 4;

	localparam int DataWidth = 64;

	// credits the downstream side grants after reset
	localparam int CreditCount = 4;
	localparam int CreditWidth = $clog2(CreditCount + 1);

	// top nibble marking an untranslated physical address
	localparam logic [3:0] PhysWindowNibble = 4'hC;

endpackage

`default_nettype wire

//--- memOpPkg.sv
// request opcodes, exception codes, TLB entry layouts and the request data word
`default_nettype none

package memOpPkg;

	typedef enum logic [2:0] {
		OpIdle = 3'd0,
		OpLoad = 3'd1,
		OpStore = 3'd2,
		OpLoadTlb = 3'd3,
		OpInvTlb = 3'd4
	} memOp_t;

	typedef enum logic [1:0] {
		ExcNone = 2'd0,
		ExcTlbMiss = 2'd1
	} tlbExc_t;

	// pads the entry out to one data word
	localparam int EntryReservedWidth = tlbConfigPkg::DataWidth - tlbConfigPkg::VpnWidth
		- tlbConfigPkg::PpnWidth - tlbConfigPkg::AsidWidth - 1;

	// translation as carried by a load-TLB request
	typedef struct packed {
		logic [tlbConfigPkg::VpnWidth-1:0] vpn;
		logic [tlbConfigPkg::PpnWidth-1:0] ppn;
		logic [tlbConfigPkg::AsidWidth-1:0] asid;
		logic [EntryReservedWidth-1:0] reserved;
		logic valid;
	} tlbEntry_t;

	// one way of a set, stamped with the generation it was loaded in
	typedef struct packed {
		logic [tlbConfigPkg::GenWidth-1:0] gen;
		tlbEntry_t entry;
	} tlbStoredEntry_t;

	// store data for a store, a TLB entry for a load-TLB request
	typedef union packed {
		logic [tlbConfigPkg::DataWidth-1:0] raw;
		tlbEntry_t entry;
	} tlbDataWord_t;

endpackage

`default_nettype wire

//--- tlbSetArray.sv
// four-way TLB set storage with per-set loaded flags and write-to-read forwarding
`timescale 1ns/10ps
`default_nettype none

module tlbSetArray
(
	input logic clock,
	input logic reset,
	input logic readEnable,
	input logic [tlbConfigPkg::SetIndexWidth-1:0] readIndex,
	input logic writeEnable,
	input logic [tlbConfigPkg::SetIndexWidth-1:0] writeIndex,
	input memOpPkg::tlbStoredEntry_t [tlbConfigPkg::WayCount-1:0] writeSet,
	output memOpPkg::tlbStoredEntry_t [tlbConfigPkg::WayCount-1:0] setWays
);
	import tlbConfigPkg::*;
	import memOpPkg::*;

	tlbStoredEntry_t [WayCount-1:0] sets [SetCount];
	logic [SetCount-1:0] loaded;

	tlbStoredEntry_t [WayCount-1:0] readData;
	logic readLoaded;
	logic sameSet;

	assign sameSet = writeEnable && (writeIndex == readIndex);

	always_ff @(posedge clock)
	begin
		if (writeEnable)
			sets[writeIndex] <= writeSet;
		// a set written on this edge is returned as written
		if (readEnable)
			readData <= sameSet ? writeSet : sets[readIndex];
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			loaded <= '0;
			readLoaded <= 1'b0;
		end
		else
		begin
			if (writeEnable)
				loaded[writeIndex] <= 1'b1;
			if (readEnable)
				readLoaded <= sameSet || loaded[readIndex];
		end
	end

	// never-written sets hold garbage, so hide their valid bits
	always_comb
	begin
		setWays = readData;
		for (int i = 0; i < WayCount; i++)
			setWays[i].entry.valid = readData[i].entry.valid && readLoaded;
	end

endmodule

`default_nettype wire

//--- tlbWayMatch.sv
// TLB way comparison and hit-way physical page select
`timescale 1ns/10ps
`default_nettype none

module tlbWayMatch
(
	input memOpPkg::tlbStoredEntry_t [tlbConfigPkg::WayCount-1:0] setWays,
	input logic [tlbConfigPkg::VpnWidth-1:0] stageVpn,
	input logic [tlbConfigPkg::AsidWidth-1:0] stageAsid,
	input logic [tlbConfigPkg::GenWidth-1:0] stageGen,
	output logic hit,
	output logic [tlbConfigPkg::WayIndexWidth-1:0] hitWay,
	output logic [tlbConfigPkg::PpnWidth-1:0] hitPpn
);
	import tlbConfigPkg::*;

	logic [WayCount-1:0] wayHit;

	// stale generation counts as invalid
	always_comb
	begin
		for (int i = 0; i < WayCount; i++)
		begin
			wayHit[i] = setWays[i].entry.valid
				&& (setWays[i].gen == stageGen)
				&& (setWays[i].entry.vpn == stageVpn)
				&& (setWays[i].entry.asid == stageAsid);
		end
	end

	// descending scan so the lowest hit way wins
	always_comb
	begin
		hitWay = '0;
		hitPpn = setWays[0].entry.ppn;
		for (int i = WayCount - 1; i >= 0; i--)
		begin
			if (wayHit[i])
			begin
				hitWay = WayIndexWidth'(i);
				hitPpn = setWays[i].entry.ppn;
			end
		end
	end

	assign hit = |wayHit;

endmodule

`default_nettype wire

//--- tlbReplaceShuffle.sv
// new TLB set contents for an insert or a most-recently-used promotion
`timescale 1ns/10ps
`default_nettype none

module tlbReplaceShuffle
(
	input memOpPkg::tlbStoredEntry_t [tlbConfigPkg::WayCount-1:0] setWays,
	input logic stageIsInsert,
	input memOpPkg::tlbEntry_t stageEntry,
	input logic [tlbConfigPkg::GenWidth-1:0] stageGen,
	input logic [tlbConfigPkg::WayIndexWidth-1:0] hitWay,
	output memOpPkg::tlbStoredEntry_t [tlbConfigPkg::WayCount-1:0] newSet
);
	import tlbConfigPkg::*;

	// way 0 is most recent, the last way is next to go
	always_comb
	begin
		newSet = setWays;
		if (stageIsInsert)
		begin
			// oldest way falls off the end
			for (int i = WayCount - 1; i > 0; i--)
				newSet[i] = setWays[i-1];
			newSet[0].entry = stageEntry;
			newSet[0].gen = stageGen;
		end
		else
		begin
			// ways above the hit keep their place
			for (int i = 1; i < WayCount; i++)
			begin
				if (i <= int'(hitWay))
					newSet[i] = setWays[i-1];
			end
			newSet[0] = setWays[hitWay];
		end
	end

endmodule

`default_nettype wire

//--- tlbController.sv
// TLB control: request decode, stage-1 register, response credits, generation and response forming
`timescale 1ns/10ps
`default_nettype none

module tlbController
(
	input logic clock,
	input logic reset,
	input logic mmuEnable,
	input logic [tlbConfigPkg::AsidWidth-1:0] asid,
	input logic reqValid,
	input memOpPkg::memOp_t reqOp,
	input logic [tlbConfigPkg::VirtAddrWidth-1:0] reqAddr,
	input memOpPkg::tlbDataWord_t reqData,
	input logic respCredit,
	input logic hit,
	input logic [tlbConfigPkg::WayIndexWidth-1:0] hitWay,
	input logic [tlbConfigPkg::PpnWidth-1:0] hitPpn,
	input memOpPkg::tlbStoredEntry_t [tlbConfigPkg::WayCount-1:0] newSet,
	output logic reqReady,
	output logic readEnable,
	output logic [tlbConfigPkg::SetIndexWidth-1:0] readIndex,
	output logic writeEnable,
	output logic [tlbConfigPkg::SetIndexWidth-1:0] writeIndex,
	output memOpPkg::tlbStoredEntry_t [tlbConfigPkg::WayCount-1:0] writeSet,
	output logic [tlbConfigPkg::AsidWidth-1:0] stageAsid,
	output logic [tlbConfigPkg::VpnWidth-1:0] stageVpn,
	output logic [tlbConfigPkg::GenWidth-1:0] stageGen,
	output logic stageIsInsert,
	output memOpPkg::tlbEntry_t stageEntry,
	output logic respValid,
	output memOpPkg::memOp_t respOp,
	output logic [tlbConfigPkg::PhysAddrWidth-1:0] respAddr,
	output logic [tlbConfigPkg::DataWidth-1:0] respData,
	output memOpPkg::tlbExc_t respExc
);
	import tlbConfigPkg::*;
	import memOpPkg::*;

	// stage 1
	logic stageValid;
	memOp_t stageOp;
	logic [VirtAddrWidth-1:0] stageAddr;
	tlbDataWord_t stageData;
	logic [SetIndexWidth-1:0] stageIndex;
	logic stageBypass;

	logic [GenWidth-1:0] genCount;
	logic [CreditWidth-1:0] creditCount;

	logic take;
	logic needsResp;
	logic stall;
	logic respFire;
	logic stageIsXlate;
	logic [PhysAddrWidth-1:0] nextAddr;
	tlbExc_t nextExc;

	// a response waiting on a credit holds stage 1 and the request side
	assign needsResp = stageValid && (stageOp == OpLoad || stageOp == OpStore);
	assign stall = needsResp && (creditCount == '0);
	assign respFire = needsResp && !stall;
	assign reqReady = !stall;
	assign take = reqValid && reqReady && (reqOp != OpIdle);

	// an insert indexes by the entry's own vpn
	assign readEnable = take;
	assign readIndex = (reqOp == OpLoadTlb) ? reqData.entry.vpn[SetIndexWidth-1:0]
		: reqAddr[PageOffsetWidth +: SetIndexWidth];

	always_ff @(posedge clock)
	begin
		if (reset)
			stageValid <= 1'b0;
		else if (!stall)
			stageValid <= take;
	end

	always_ff @(posedge clock)
	begin
		if (take)
		begin
			stageOp <= reqOp;
			stageAddr <= reqAddr;
			stageData <= reqData;
			stageIndex <= readIndex;
			stageAsid <= asid;
			stageBypass <= !mmuEnable
				|| (reqAddr[VirtAddrWidth-1 -: 4] == PhysWindowNibble);
		end
	end

	assign stageVpn = stageAddr[VirtAddrWidth-1:PageOffsetWidth];
	assign stageEntry = stageData.entry;
	assign stageGen = genCount;
	assign stageIsInsert = stageValid && (stageOp == OpLoadTlb);
	assign stageIsXlate = needsResp && !stageBypass;

	// generation bump retires every entry stamped before it
	always_ff @(posedge clock)
	begin
		if (reset)
			genCount <= '0;
		else if (stageValid && stageOp == OpInvTlb)
			genCount <= genCount + 1'b1;
	end

	// promotion of way 0 changes nothing, so no write
	assign writeEnable = stageIsInsert || (stageIsXlate && !stall && hit && hitWay != '0);
	assign writeIndex = stageIndex;
	assign writeSet = newSet;

	always_comb
	begin
		nextAddr = stageAddr;
		nextExc = ExcNone;
		if (stageIsXlate)
		begin
			if (hit)
				nextAddr = {hitPpn, stageAddr[PageOffsetWidth-1:0]};
			else
				nextExc = ExcTlbMiss;
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			respValid <= 1'b0;
			creditCount <= CreditWidth'(CreditCount);
		end
		else
		begin
			respValid <= respFire;
			creditCount <= creditCount - CreditWidth'(respFire) + CreditWidth'(respCredit);
		end
	end

	always_ff @(posedge clock)
	begin
		if (respFire)
		begin
			respOp <= stageOp;
			respAddr <= nextAddr;
			respData <= stageData.raw;
			respExc <= nextExc;
		end
	end

endmodule

`default_nettype wire

//--- tlbTop.sv
// TLB top level joining the controller, set storage, way match and replacement shuffle
`timescale 1ns/10ps
`default_nettype none

module tlbTop
(
	input logic clock,
	input logic reset,
	input logic mmuEnable,
	input logic [tlbConfigPkg::AsidWidth-1:0] asid,
	input logic reqValid,
	input memOpPkg::memOp_t reqOp,
	input logic [tlbConfigPkg::VirtAddrWidth-1:0] reqAddr,
	input memOpPkg::tlbDataWord_t reqData,
	output logic reqReady,
	output logic respValid,
	output memOpPkg::memOp_t respOp,
	output logic [tlbConfigPkg::PhysAddrWidth-1:0] respAddr,
	output logic [tlbConfigPkg::DataWidth-1:0] respData,
	output memOpPkg::tlbExc_t respExc,
	input logic respCredit
);
	import tlbConfigPkg::*;
	import memOpPkg::*;

	logic readEnable;
	logic [SetIndexWidth-1:0] readIndex;
	logic writeEnable;
	logic [SetIndexWidth-1:0] writeIndex;
	tlbStoredEntry_t [WayCount-1:0] writeSet;
	tlbStoredEntry_t [WayCount-1:0] setWays;
	tlbStoredEntry_t [WayCount-1:0] newSet;

	// stage-1 request fields seen by the datapath
	logic [AsidWidth-1:0] stageAsid;
	logic [VpnWidth-1:0] stageVpn;
	logic [GenWidth-1:0] stageGen;
	logic stageIsInsert;
	tlbEntry_t stageEntry;

	logic hit;
	logic [WayIndexWidth-1:0] hitWay;
	logic [PpnWidth-1:0] hitPpn;

	tlbController controller (
		.clock(clock), .reset(reset), .mmuEnable(mmuEnable), .asid(asid),
		.reqValid(reqValid), .reqOp(reqOp), .reqAddr(reqAddr), .reqData(reqData),
		.respCredit(respCredit), .hit(hit), .hitWay(hitWay), .hitPpn(hitPpn),
		.newSet(newSet), .reqReady(reqReady), .readEnable(readEnable),
		.readIndex(readIndex), .writeEnable(writeEnable), .writeIndex(writeIndex),
		.writeSet(writeSet), .stageAsid(stageAsid), .stageVpn(stageVpn),
		.stageGen(stageGen), .stageIsInsert(stageIsInsert), .stageEntry(stageEntry),
		.respValid(respValid), .respOp(respOp), .respAddr(respAddr),
		.respData(respData), .respExc(respExc)
	);

	tlbSetArray setArray (
		.clock(clock), .reset(reset), .readEnable(readEnable), .readIndex(readIndex),
		.writeEnable(writeEnable), .writeIndex(writeIndex), .writeSet(writeSet),
		.setWays(setWays)
	);

	tlbWayMatch wayMatch (
		.setWays(setWays), .stageVpn(stageVpn), .stageAsid(stageAsid),
		.stageGen(stageGen), .hit(hit), .hitWay(hitWay), .hitPpn(hitPpn)
	);

	tlbReplaceShuffle replaceShuffle (
		.setWays(setWays), .stageIsInsert(stageIsInsert), .stageEntry(stageEntry),
		.stageGen(stageGen), .hitWay(hitWay), .newSet(newSet)
	);

endmodule

`default_nettype wire

//--- tlbProperties.sv
// concurrent checks on the TLB controller response credits and reset state
`timescale 1ns/10ps
`default_nettype none

module tlbProperties
(
	input logic clock,
	input logic reset,
	input logic respValid,
	input logic writeEnable,
	input logic [tlbConfigPkg::CreditWidth-1:0] creditCount
);
	import tlbConfigPkg::*;

	// a response spends a credit that existed on its firing edge
	responseNeedsCredit: assert property (@(posedge clock) disable iff (reset)
		respValid |-> $past(creditCount) != '0)
		else $error("response issued while the credit counter was zero");

	quietAfterReset: assert property (@(posedge clock)
		reset |=> !respValid && !writeEnable)
		else $error("response or set write in the cycle after reset");

	creditBound: assert property (@(posedge clock) disable iff (reset)
		creditCount <= CreditWidth'(CreditCount))
		else $error("credit counter above the credits granted after reset");

endmodule

bind tlbController tlbProperties controllerProps (
	.clock(clock),
	.reset(reset),
	.respValid(respValid),
	.writeEnable(writeEnable),
	.creditCount(creditCount)
);

`default_nettype wire

//--- tlbTb.sv
// TLB testbench with clock, reset, seeded random stimulus, reference model, checks and watchdog
`timescale 1ns/10ps
`default_nettype none

module tlbTb;
	import tlbConfigPkg::*;
	import memOpPkg::*;

	localparam int RandomRequests = 300;
	localparam int DirectedRequests = 80;
	localparam int WatchdogCycles = (RandomRequests + DirectedRequests) * 40;
	localparam int DrainLimit = 200;

	typedef struct packed {
		memOp_t op;
		logic [PhysAddrWidth-1:0] addr;
		logic [DataWidth-1:0] data;
		tlbExc_t exc;
	} expResp_t;

	logic clock;
	logic reset;
	logic mmuEnable;
	logic [AsidWidth-1:0] asid;
	logic reqValid;
	memOp_t reqOp;
	logic [VirtAddrWidth-1:0] reqAddr;
	tlbDataWord_t reqData;
	logic reqReady;
	logic respValid;
	memOp_t respOp;
	logic [PhysAddrWidth-1:0] respAddr;
	logic [DataWidth-1:0] respData;
	tlbExc_t respExc;
	logic respCredit;

	// reference model with way 0 as most recent
	tlbEntry_t modelWays [SetCount][WayCount];
	logic [GenWidth-1:0] modelStamp [SetCount][WayCount];
	logic modelLoaded [SetCount];
	logic [GenWidth-1:0] modelGen;
	expResp_t expQ [$];
	expResp_t expected;

	int creditPercent;
	int pendingCredits;
	int checkCount;
	int errorCount;
	int testErrors;
	int requestCount;
	int seedValue;
	logic [VpnWidth-1:0] vpnPool [12];
	logic [AsidWidth-1:0] asidPool [3];

	tlbTop UUT (.*);

	initial
	begin
		clock = 1'b0;
		forever
			#2 clock = ~clock;
	end

	initial
	begin
		repeat (WatchdogCycles) @(posedge clock);
		$display("watchdog expired after %0d cycles with requests still open", WatchdogCycles);
		$display("Result: FAILED");
		$finish;
	end

	function automatic tlbDataWord_t randomWord();
		tlbDataWord_t word;
		word.raw = {$urandom, $urandom};
		return word;
	endfunction

	task automatic applyModel(input memOp_t op, input logic [VirtAddrWidth-1:0] addr,
			input tlbDataWord_t data, input logic [AsidWidth-1:0] reqAsid, input logic enable);
		int idx;
		int hitAt;
		tlbEntry_t moved;
		logic [GenWidth-1:0] movedStamp;
		expResp_t resp;
		if (op == OpInvTlb)
			modelGen = modelGen + 1'b1;
		else if (op == OpLoadTlb)
		begin
			idx = int'(data.entry.vpn[SetIndexWidth-1:0]);
			// oldest way drops out, unloaded sets shift in empty ways
			for (int w = WayCount - 1; w > 0; w--)
			begin
				modelWays[idx][w] = modelWays[idx][w-1];
				modelStamp[idx][w] = modelStamp[idx][w-1];
				modelWays[idx][w].valid = modelWays[idx][w].valid && modelLoaded[idx];
			end
			modelWays[idx][0] = data.entry;
			modelStamp[idx][0] = modelGen;
			modelLoaded[idx] = 1'b1;
		end
		else if (op == OpLoad || op == OpStore)
		begin
			resp.op = op;
			resp.addr = addr;
			resp.data = data.raw;
			resp.exc = ExcNone;
			if (enable && addr[VirtAddrWidth-1 -: 4] != PhysWindowNibble)
			begin
				idx = int'(addr[PageOffsetWidth +: SetIndexWidth]);
				hitAt = -1;
				for (int w = WayCount - 1; w >= 0; w--)
				begin
					if (modelLoaded[idx] && modelWays[idx][w].valid
						&& modelStamp[idx][w] == modelGen
						&& modelWays[idx][w].vpn == addr[VirtAddrWidth-1:PageOffsetWidth]
						&& modelWays[idx][w].asid == reqAsid)
						hitAt = w;
				end
				if (hitAt < 0)
					resp.exc = ExcTlbMiss;
				else
				begin
					resp.addr = {modelWays[idx][hitAt].ppn, addr[PageOffsetWidth-1:0]};
					moved = modelWays[idx][hitAt];
					movedStamp = modelStamp[idx][hitAt];
					for (int w = hitAt; w > 0; w--)
					begin
						modelWays[idx][w] = modelWays[idx][w-1];
						modelStamp[idx][w] = modelStamp[idx][w-1];
					end
					modelWays[idx][0] = moved;
					modelStamp[idx][0] = movedStamp;
				end
			end
			expQ.push_back(resp);
		end
	endtask

	// called on a rising edge, returns on the accepting edge
	task automatic issue(input memOp_t op, input logic [VirtAddrWidth-1:0] addr,
			input tlbDataWord_t data, input logic [AsidWidth-1:0] reqAsid, input logic enable);
		logic ready;
		reqValid <= 1'b1;
		reqOp <= op;
		reqAddr <= addr;
		reqData <= data;
		asid <= reqAsid;
		mmuEnable <= enable;
		ready = 1'b0;
		while (!ready)
		begin
			@(negedge clock);
			ready = reqReady;
			@(posedge clock);
		end
		applyModel(op, addr, data, reqAsid, enable);
		requestCount++;
	endtask

	task automatic loadEntry(input logic [VpnWidth-1:0] vpn, input logic [PpnWidth-1:0] ppn,
			input logic [AsidWidth-1:0] entryAsid);
		tlbDataWord_t word;
		word = randomWord();
		word.entry.vpn = vpn;
		word.entry.ppn = ppn;
		word.entry.asid = entryAsid;
		word.entry.valid = 1'b1;
		issue(OpLoadTlb, $urandom, word, entryAsid, 1'b1);
	endtask

	task automatic access(input logic [VpnWidth-1:0] vpn, input logic [AsidWidth-1:0] reqAsid,
			input logic enable);
		issue(($urandom_range(0, 1) == 0) ? OpLoad : OpStore,
			{vpn, PageOffsetWidth'($urandom)}, randomWord(), reqAsid, enable);
	endtask

	task automatic invalidate();
		issue(OpInvTlb, $urandom, randomWord(), '0, 1'b1);
	endtask

	task automatic checkResponse();
		pendingCredits++;
		checkCount += 2;
		assert (pendingCredits <= CreditCount)
		else
		begin
			$display("Fail %0t: %0d responses outstanding", $time, pendingCredits);
			errorCount++;
		end
		assert (expQ.size() > 0)
		else
		begin
			$display("response at %0t arrived with no request outstanding", $time);
			errorCount++;
		end
		if (expQ.size() > 0)
		begin
			expected = expQ.pop_front();
			checkCount++;
			// fields shown as op/addr/exc/data
			assert (respOp == expected.op && respAddr == expected.addr
				&& respData == expected.data && respExc == expected.exc)
			else
			begin
				$display("Fail %0t: got %0d/%h/%0d/%h expected %0d/%h/%0d/%h", $time,
					respOp, respAddr, respExc, respData,
					expected.op, expected.addr, expected.exc, expected.data);
				errorCount++;
			end
		end
	endtask

	// response checks and credit return
	initial
	begin
		respCredit = 1'b0;
		forever
		begin
			@(negedge clock);
			if (respValid === 1'b1)
				checkResponse();
			@(posedge clock);
			if (pendingCredits > 0 && $urandom_range(0, 99) < creditPercent)
			begin
				respCredit <= 1'b1;
				pendingCredits--;
			end
			else
				respCredit <= 1'b0;
		end
	end

	task automatic finishTest(input string name);
		int waited;
		reqValid <= 1'b0;
		waited = 0;
		while (expQ.size() != 0 && waited < DrainLimit)
		begin
			@(posedge clock);
			waited++;
		end
		checkCount++;
		assert (expQ.size() == 0)
		else
		begin
			$display("%0d responses never arrived within %0d cycles", expQ.size(), DrainLimit);
			errorCount++;
		end
		$display("%s test finished with %0d errors", name, errorCount - testErrors);
		testErrors = errorCount;
	endtask

	task automatic randomTest();
		int pick;
		int slot;
		logic [AsidWidth-1:0] pickAsid;
		asidPool[0] = 8'h21;
		asidPool[1] = 8'h47;
		asidPool[2] = 8'h9a;
		// few sets so inserts collide and evict
		for (int i = 0; i < 12; i++)
			vpnPool[i] = {1'b0, 15'($urandom), SetIndexWidth'($urandom_range(0, 3))};
		creditPercent = 15;
		for (int n = 0; n < RandomRequests; n++)
		begin
			pick = int'($urandom_range(0, 99));
			slot = int'($urandom_range(0, 11));
			pickAsid = asidPool[int'($urandom_range(0, 2))];
			if (pick < 4)
				invalidate();
			else if (pick < 25)
				loadEntry(vpnPool[slot], PpnWidth'($urandom), pickAsid);
			else if (pick < 35)
				access({PhysWindowNibble, 16'($urandom)}, pickAsid, 1'b1);
			else
				access(vpnPool[slot], pickAsid, $urandom_range(0, 9) != 0);
			if ($urandom_range(0, 4) == 0)
			begin
				reqValid <= 1'b0;
				repeat ($urandom_range(1, 3)) @(posedge clock);
			end
		end
	endtask

	initial
	begin
		seedValue = $urandom(40);
		reset = 1'b1;
		mmuEnable = 1'b1;
		asid = '0;
		reqValid = 1'b0;
		reqOp = OpIdle;
		reqAddr = '0;
		reqData = '0;
		creditPercent = 100;
		modelGen = '0;
		for (int s = 0; s < SetCount; s++)
			modelLoaded[s] = 1'b0;
		repeat (16) @(posedge clock);
		reset <= 1'b0;

		for (int i = 0; i < 4; i++)
			loadEntry({16'h1230 + 16'(i), 4'(i)}, PpnWidth'($urandom), 8'h21);
		for (int i = 0; i < 8; i++)
			access({16'h1230 + 16'(i % 4), 4'(i % 4)}, 8'h21, 1'b1);
		finishTest("load-TLB hit");

		access({16'h5555, 4'h7}, 8'h21, 1'b1);
		access({16'h7777, 4'h1}, 8'h21, 1'b1);
		access({16'h1230, 4'h0}, 8'h99, 1'b1);
		access({16'h1231, 4'h1}, 8'h47, 1'b1);
		finishTest("miss");

		invalidate();
		for (int i = 0; i < 4; i++)
			access({16'h1230 + 16'(i), 4'(i)}, 8'h21, 1'b1);
		loadEntry({16'h1232, 4'h2}, PpnWidth'($urandom), 8'h21);
		access({16'h1232, 4'h2}, 8'h21, 1'b1);
		access({16'h1233, 4'h3}, 8'h21, 1'b1);
		finishTest("invalidate");

		// one set with promotions between inserts
		for (int i = 0; i < 4; i++)
			loadEntry({16'h2000 + 16'(i), 4'h9}, PpnWidth'($urandom), 8'h33);
		access({16'h2000, 4'h9}, 8'h33, 1'b1);
		loadEntry({16'h2004, 4'h9}, PpnWidth'($urandom), 8'h33);
		access({16'h2002, 4'h9}, 8'h33, 1'b1);
		loadEntry({16'h2005, 4'h9}, PpnWidth'($urandom), 8'h33);
		for (int i = 0; i < 6; i++)
			access({16'h2000 + 16'(i), 4'h9}, 8'h33, 1'b1);
		finishTest("eviction order");

		for (int i = 0; i < 4; i++)
			access({PhysWindowNibble, 16'($urandom)}, 8'h21, 1'b1);
		// reverse order would reshuffle the set if bypass promoted
		for (int i = 0; i < 6; i++)
			access({16'h2005 - 16'(i), 4'h9}, 8'h33, 1'b0);
		loadEntry({16'h2006, 4'h9}, PpnWidth'($urandom), 8'h33);
		for (int i = 0; i < 7; i++)
			access({16'h2000 + 16'(i), 4'h9}, 8'h33, 1'b1);
		finishTest("bypass");

		randomTest();
		finishTest("random with credit starvation");

		$display("requests %0d, checks %0d, errors %0d", requestCount, checkCount, errorCount);
		if (errorCount == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
tlbConfigPkg.sv
memOpPkg.sv
tlbSetArray.sv
tlbWayMatch.sv
tlbReplaceShuffle.sv
tlbController.sv
tlbTop.sv
tlbProperties.sv
tlbTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tlbTb
FILE_LIST ?= files.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
FAIL_TEXT ?= Result: FAILED
PASS_TEXT ?= Result: PASSED
VFLAGS ?= --binary --timing --assert --timescale 1ns/10ps

SOURCES := $(shell cat $(FILE_LIST))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "simulation ended without a result"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
